/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_alu_backend
OBJ_DIR   ?= obj_dir
FILELIST  ?= build.f
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell cat $(FILELIST))
BIN  ?= $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only when the pass line shows up in the simulator output
run: $(BIN)
	@out="$$($(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '\*\* PASS \*\*'

clean:
	rm -rf $(OBJ_DIR)

/* alu_backend.sv */
`timescale 1ns/1ns

module alu_backend
    import ooo_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    flush,
    input  logic    disp_valid,
    input  alu_op_e disp_op,
    input  preg_t   disp_src_l,
    input  preg_t   disp_src_r,
    input  preg_t   disp_dst,
    input  imm_t    disp_imm,
    output logic    disp_ready,
    output logic    wb0_valid,
    output preg_t   wb0_preg,
    output word_t   wb0_data,
    output logic    wb1_valid,
    output preg_t   wb1_preg,
    output word_t   wb1_data
);

    sb_query_if sb_q ();
    issue_if    issue0 ();
    issue_if    issue1 ();
    prf_read_if rd0 ();
    prf_read_if rd1 ();

    alu_issue_queue iq_u (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush      (flush),
        .disp_valid (disp_valid),
        .disp_op    (disp_op),
        .disp_src_l (disp_src_l),
        .disp_src_r (disp_src_r),
        .disp_dst   (disp_dst),
        .disp_imm   (disp_imm),
        .disp_ready (disp_ready),
        .sb         (sb_q),
        .issue0     (issue0),
        .issue1     (issue1)
    );

    // wakeup happens at writeback, no speculative clear
    scoreboard sb_u (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .query     (sb_q),
        .wb0_valid (wb0_valid),
        .wb1_valid (wb1_valid),
        .wb0_preg  (wb0_preg),
        .wb1_preg  (wb1_preg)
    );

    prf prf_u (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd0       (rd0),
        .rd1       (rd1),
        .wb0_valid (wb0_valid),
        .wb1_valid (wb1_valid),
        .wb0_preg  (wb0_preg),
        .wb1_preg  (wb1_preg),
        .wb0_data  (wb0_data),
        .wb1_data  (wb1_data)
    );

    alu_lane lane0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .flush    (flush),
        .issue    (issue0),
        .rd       (rd0),
        .wb_valid (wb0_valid),
        .wb_preg  (wb0_preg),
        .wb_data  (wb0_data)
    );

    alu_lane lane1 (
        .clk      (clk),
        .rst_n    (rst_n),
        .flush    (flush),
        .issue    (issue1),
        .rd       (rd1),
        .wb_valid (wb1_valid),
        .wb_preg  (wb1_preg),
        .wb_data  (wb1_data)
    );

endmodule

/* alu_backend_properties.sv */
`timescale 1ns/1ns

module alu_backend_properties
    import ooo_pkg::*;
(
    input logic  clk,
    input logic  rst_n,
    input logic  flush,
    input logic  disp_valid,
    input logic  disp_ready,
    input logic  wb0_valid,
    input preg_t wb0_preg,
    input logic  wb1_valid,
    input preg_t wb1_preg
);

    no_disp_when_full: assert property (
        @(posedge clk) disable iff (!rst_n) !(disp_valid && !disp_ready)
    ) else $error("dispatch presented while disp_ready is low");

    // two lanes never target one register in the same cycle
    distinct_wb_pregs: assert property (
        @(posedge clk) disable iff (!rst_n) (wb0_valid && wb1_valid) |-> (wb0_preg != wb1_preg)
    ) else $error("both lanes wrote back register %0d in one cycle", wb0_preg);

    quiet_after_reset: assert property (
        @(posedge clk) $rose(rst_n) |-> (!wb0_valid && !wb1_valid)
    ) else $error("writeback valid in the first cycle after reset");

    ready_after_flush: assert property (
        @(posedge clk) disable iff (!rst_n) flush |=> disp_ready
    ) else $error("disp_ready low in the cycle after flush");

endmodule

/* alu_issue_queue.sv */
`timescale 1ns/1ns

module alu_issue_queue
    import ooo_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      flush,
    input  logic      disp_valid,
    input  alu_op_e   disp_op,
    input  preg_t     disp_src_l,
    input  preg_t     disp_src_r,
    input  preg_t     disp_dst,
    input  imm_t      disp_imm,
    output logic      disp_ready,
    sb_query_if.queue sb,
    issue_if.queue    issue0,
    issue_if.queue    issue1
);

    // entry 0 is the oldest, valid bits stay packed at the bottom
    iq_vec_t q_valid;
    alu_op_e q_op    [IQ_DEPTH];
    preg_t   q_src_l [IQ_DEPTH];
    preg_t   q_src_r [IQ_DEPTH];
    preg_t   q_dst   [IQ_DEPTH];
    imm_t    q_imm   [IQ_DEPTH];

    iq_vec_t n_valid;
    alu_op_e n_op    [IQ_DEPTH];
    preg_t   n_src_l [IQ_DEPTH];
    preg_t   n_src_r [IQ_DEPTH];
    preg_t   n_dst   [IQ_DEPTH];
    imm_t    n_imm   [IQ_DEPTH];

    iq_vec_t                ready;
    iq_vec_t                keep;
    iq_idx_t                sel [ISSUE_WIDTH];
    logic [ISSUE_WIDTH-1:0] sel_found;
    logic                   accept;

    assign disp_ready = ~q_valid[IQ_DEPTH-1] & ~flush;
    assign accept     = disp_valid & disp_ready;

    assign sb.set_valid = accept;
    assign sb.set_preg  = disp_dst;
    assign sb.src_l     = q_src_l;
    assign sb.src_r     = q_src_r;

    // addi has no right source
    always_comb begin
        for (int i = 0; i < IQ_DEPTH; i++) begin
            ready[i] = q_valid[i] & ~sb.busy_l[i] & ((q_op[i] == ALU_ADDI) | ~sb.busy_r[i]);
        end
    end

    // oldest first, up to the issue width
    always_comb begin
        int n_sel;
        n_sel     = 0;
        keep      = q_valid;
        sel_found = '0;
        for (int s = 0; s < ISSUE_WIDTH; s++) begin
            sel[s] = '0;
        end
        for (int i = 0; i < IQ_DEPTH; i++) begin
            if (ready[i] && n_sel < ISSUE_WIDTH) begin
                keep[i]          = 1'b0;
                sel[n_sel]       = iq_idx_t'(i);
                sel_found[n_sel] = 1'b1;
                n_sel++;
            end
        end
    end

    // collapse survivors downward, then append the new uop
    always_comb begin
        int wr;
        wr      = 0;
        n_valid = '0;
        n_op    = q_op;
        n_src_l = q_src_l;
        n_src_r = q_src_r;
        n_dst   = q_dst;
        n_imm   = q_imm;
        for (int i = 0; i < IQ_DEPTH; i++) begin
            if (keep[i]) begin
                n_op[wr]    = q_op[i];
                n_src_l[wr] = q_src_l[i];
                n_src_r[wr] = q_src_r[i];
                n_dst[wr]   = q_dst[i];
                n_imm[wr]   = q_imm[i];
                n_valid[wr] = 1'b1;
                wr++;
            end
        end
        if (accept && wr < IQ_DEPTH) begin
            n_op[wr]    = disp_op;
            n_src_l[wr] = disp_src_l;
            n_src_r[wr] = disp_src_r;
            n_dst[wr]   = disp_dst;
            n_imm[wr]   = disp_imm;
            n_valid[wr] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q_valid      <= '0;
            issue0.valid <= 1'b0;
            issue1.valid <= 1'b0;
        end else begin
            q_valid      <= flush ? '0 : n_valid;
            issue0.valid <= sel_found[0] & ~flush;
            issue1.valid <= sel_found[1] & ~flush;
        end
    end

    always_ff @(posedge clk) begin
        q_op    <= n_op;
        q_src_l <= n_src_l;
        q_src_r <= n_src_r;
        q_dst   <= n_dst;
        q_imm   <= n_imm;

        issue0.op    <= q_op[sel[0]];
        issue0.src_l <= q_src_l[sel[0]];
        issue0.src_r <= q_src_r[sel[0]];
        issue0.dst   <= q_dst[sel[0]];
        issue0.imm   <= q_imm[sel[0]];

        issue1.op    <= q_op[sel[1]];
        issue1.src_l <= q_src_l[sel[1]];
        issue1.src_r <= q_src_r[sel[1]];
        issue1.dst   <= q_dst[sel[1]];
        issue1.imm   <= q_imm[sel[1]];
    end

endmodule

/* alu_lane.sv */
`timescale 1ns/1ns

module alu_lane
    import ooo_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     flush,
    issue_if.lane    issue,
    prf_read_if.lane rd,
    output logic     wb_valid,
    output preg_t    wb_preg,
    output word_t    wb_data
);

    // operand stage
    logic    s2_valid;
    alu_op_e s2_op;
    preg_t   s2_dst;
    imm_t    s2_imm;
    word_t   s2_opnd_l;
    word_t   s2_opnd_r;

    word_t   imm_ext;
    word_t   alu_result;

    // register read straight off the issue register
    assign rd.num_l = issue.src_l;
    assign rd.num_r = issue.src_r;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s2_valid <= 1'b0;
            wb_valid <= 1'b0;
        end else begin
            s2_valid <= issue.valid & ~flush;
            wb_valid <= s2_valid & ~flush;
        end
    end

    always_ff @(posedge clk) begin
        s2_op     <= issue.op;
        s2_dst    <= issue.dst;
        s2_imm    <= issue.imm;
        s2_opnd_l <= rd.data_l;
        s2_opnd_r <= rd.data_r;
        wb_preg   <= s2_dst;
        wb_data   <= alu_result;
    end

    assign imm_ext = {{(XLEN-IMM_W){s2_imm[IMM_W-1]}}, s2_imm};

    always_comb begin
        case (s2_op)
            ALU_ADD:  alu_result = s2_opnd_l + s2_opnd_r;
            ALU_SUB:  alu_result = s2_opnd_l - s2_opnd_r;
            ALU_AND:  alu_result = s2_opnd_l & s2_opnd_r;
            ALU_OR:   alu_result = s2_opnd_l | s2_opnd_r;
            ALU_XOR:  alu_result = s2_opnd_l ^ s2_opnd_r;
            ALU_SLL:  alu_result = s2_opnd_l << s2_opnd_r[SHAMT_W-1:0];
            ALU_SRL:  alu_result = s2_opnd_l >> s2_opnd_r[SHAMT_W-1:0];
            ALU_SLT:  alu_result = word_t'($signed(s2_opnd_l) < $signed(s2_opnd_r));
            ALU_ADDI: alu_result = s2_opnd_l + imm_ext;
            default:  alu_result = '0;
        endcase
    end

endmodule

/* build.f */
ooo_pkg.sv
ooo_ifs.sv
scoreboard.sv
alu_issue_queue.sv
prf.sv
alu_lane.sv
alu_backend.sv
alu_backend_properties.sv
tb_checker.sv
tb_alu_backend.sv

/* ooo_ifs.sv */
`timescale 1ns/1ns

// source lookups from the queue entries, plus the busy set at enqueue
interface sb_query_if import ooo_pkg::*; ();
    preg_t   src_l [IQ_DEPTH];
    preg_t   src_r [IQ_DEPTH];
    iq_vec_t busy_l;
    iq_vec_t busy_r;
    logic    set_valid;
    preg_t   set_preg;

    modport queue (
        output src_l,
        output src_r,
        output set_valid,
        output set_preg,
        input  busy_l,
        input  busy_r
    );

    modport board (
        input  src_l,
        input  src_r,
        input  set_valid,
        input  set_preg,
        output busy_l,
        output busy_r
    );
endinterface

// one issued uop, registered in the queue
interface issue_if import ooo_pkg::*; ();
    logic    valid;
    alu_op_e op;
    preg_t   src_l;
    preg_t   src_r;
    preg_t   dst;
    imm_t    imm;

    modport queue (output valid, output op, output src_l, output src_r, output dst, output imm);
    modport lane  (input valid, input op, input src_l, input src_r, input dst, input imm);
endinterface

interface prf_read_if import ooo_pkg::*; ();
    preg_t num_l;
    preg_t num_r;
    word_t data_l;
    word_t data_r;

    modport lane (output num_l, output num_r, input data_l, input data_r);
    modport file (input num_l, input num_r, output data_l, output data_r);
endinterface

/* ooo_pkg.sv */
package ooo_pkg;

    localparam int XLEN        = 32;
    localparam int PREG_COUNT  = 64;
    localparam int PREG_W      = $clog2(PREG_COUNT);
    localparam int IQ_DEPTH    = 8;
    localparam int IQ_IDX_W    = $clog2(IQ_DEPTH);
    localparam int ISSUE_WIDTH = 2;
    localparam int IMM_W       = 16;
    localparam int SHAMT_W     = $clog2(XLEN);

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [PREG_W-1:0]     preg_t;
    typedef logic [PREG_COUNT-1:0] preg_vec_t;
    typedef logic [IMM_W-1:0]      imm_t;
    typedef logic [IQ_DEPTH-1:0]   iq_vec_t;
    typedef logic [IQ_IDX_W-1:0]   iq_idx_t;

    // shifts take the low bits of the right operand, slt is signed
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SLT  = 4'd7,
        ALU_ADDI = 4'd8
    } alu_op_e;

endpackage

/* prf.sv */
`timescale 1ns/1ns

module prf
    import ooo_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    prf_read_if.file  rd0,
    prf_read_if.file  rd1,
    input  logic      wb0_valid,
    input  logic      wb1_valid,
    input  preg_t     wb0_preg,
    input  preg_t     wb1_preg,
    input  word_t     wb0_data,
    input  word_t     wb1_data
);

    word_t regs [PREG_COUNT];

    // lanes never target the same register in one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < PREG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wb0_valid)
                regs[wb0_preg] <= wb0_data;
            if (wb1_valid)
                regs[wb1_preg] <= wb1_data;
        end
    end

    assign rd0.data_l = regs[rd0.num_l];
    assign rd0.data_r = regs[rd0.num_r];
    assign rd1.data_l = regs[rd1.num_l];
    assign rd1.data_r = regs[rd1.num_r];

endmodule

/* scoreboard.sv */
`timescale 1ns/1ns

module scoreboard
    import ooo_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      flush,
    sb_query_if.board query,
    input  logic      wb0_valid,
    input  logic      wb1_valid,
    input  preg_t     wb0_preg,
    input  preg_t     wb1_preg
);

    preg_vec_t busy;

    // set after the clears so a new destination wins
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= '0;
        end else if (flush) begin
            busy <= '0;
        end else begin
            if (wb0_valid)
                busy[wb0_preg] <= 1'b0;
            if (wb1_valid)
                busy[wb1_preg] <= 1'b0;
            if (query.set_valid)
                busy[query.set_preg] <= 1'b1;
        end
    end

    always_comb begin
        for (int i = 0; i < IQ_DEPTH; i++) begin
            query.busy_l[i] = busy[query.src_l[i]];
            query.busy_r[i] = busy[query.src_r[i]];
        end
    end

endmodule

/* tb_alu_backend.sv */
`timescale 1ns/1ns

module tb_alu_backend
    import ooo_pkg::*;
();

    logic      clk;
    logic      rst_n;
    logic      flush;
    logic      disp_valid;
    alu_op_e   disp_op;
    preg_t     disp_src_l;
    preg_t     disp_src_r;
    preg_t     disp_dst;
    imm_t      disp_imm;
    logic      disp_ready;
    logic      wb0_valid;
    preg_t     wb0_preg;
    word_t     wb0_data;
    logic      wb1_valid;
    preg_t     wb1_preg;
    word_t     wb1_data;

    logic      done;
    preg_vec_t pending;
    preg_vec_t poisoned;
    preg_vec_t readers;
    int        pending_count;
    int        mismatch_errors;
    int        other_errors;
    int        timeout_errors;

    logic [31:0] lfsr;
    preg_t       last_dst;

    alu_backend alu_backend_i (.*);

    tb_checker checker_i (.*);

    bind alu_backend alu_backend_properties props_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val  = {val[30:0], lfsr[0]};
        end
        return val;
    endfunction

    // first allowed register at or above start, wrapping
    function automatic preg_t pick(input preg_t start, input preg_vec_t ok);
        preg_t p;
        p = start;
        for (int i = 0; i < PREG_COUNT; i++) begin
            if (ok[p])
                return p;
            p = p + preg_t'(1);
        end
        return start;
    endfunction

    task automatic send_uop(input logic chain);
        preg_vec_t dst_ok;
        preg_t     sl;
        preg_t     sr;
        if (chain)
            sl = last_dst;
        else if (rand_bits(1) != 0 && pending != '0)
            sl = pick(preg_t'(rand_bits(6)), pending);
        else
            sl = pick(preg_t'(rand_bits(6)), ~poisoned);
        sr = pick(preg_t'(rand_bits(6)), ~poisoned);
        // no waw on pending, no war against pending readers
        dst_ok     = ~pending & ~readers;
        dst_ok[sl] = 1'b0;
        dst_ok[sr] = 1'b0;
        disp_valid = 1'b1;
        disp_op    = alu_op_e'(4'(rand_bits(4) % 9));
        disp_src_l = sl;
        disp_src_r = sr;
        disp_dst   = pick(preg_t'(rand_bits(6)), dst_ok);
        disp_imm   = imm_t'(rand_bits(16));
        last_dst   = disp_dst;
    endtask

    task automatic run_random(input int cycles, input logic allow_flush);
        logic was_flush;
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            was_flush  = flush;
            flush      = 1'b0;
            disp_valid = 1'b0;
            if (allow_flush && !was_flush && rand_bits(6) == 0)
                flush = 1'b1;
            else if (!was_flush && disp_ready && rand_bits(2) != 0)
                send_uop(1'b0);
        end
    endtask

    task automatic run_chain(input int n);
        int sent;
        int idle;
        sent = 0;
        idle = 0;
        while (sent < n && idle < 200) begin
            @(negedge clk);
            flush      = 1'b0;
            disp_valid = 1'b0;
            if (disp_ready) begin
                send_uop(1'b1);
                sent++;
                idle = 0;
            end else begin
                idle++;
            end
        end
        if (sent < n) begin
            $display("dispatch stayed blocked for 200 cycles during the chain");
            timeout_errors++;
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (pending_count != 0 && waited < 500) begin
            @(negedge clk);
            flush      = 1'b0;
            disp_valid = 1'b0;
            waited++;
        end
        if (pending_count != 0) begin
            $display("%0d uops still pending after 500 idle cycles", pending_count);
            timeout_errors++;
        end
    endtask

    initial begin
        lfsr           = 32'd97722;
        rst_n          = 1'b0;
        flush          = 1'b0;
        disp_valid     = 1'b0;
        disp_op        = ALU_ADD;
        disp_src_l     = '0;
        disp_src_r     = '0;
        disp_dst       = '0;
        disp_imm       = '0;
        done           = 1'b0;
        last_dst       = '0;
        timeout_errors = 0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        run_random(400, 1'b0);
        run_chain(24);
        run_random(600, 1'b1);
        drain();
        done = 1'b1;
        @(negedge clk);
        done = 1'b0;
        $display("errors: %0d mismatch, %0d other, %0d timeout", mismatch_errors,
                 other_errors, timeout_errors);
        if (mismatch_errors + other_errors + timeout_errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

/* tb_checker.sv */
`timescale 1ns/1ns

module tb_checker
    import ooo_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      flush,
    input  logic      disp_valid,
    input  alu_op_e   disp_op,
    input  preg_t     disp_src_l,
    input  preg_t     disp_src_r,
    input  preg_t     disp_dst,
    input  imm_t      disp_imm,
    input  logic      disp_ready,
    input  logic      wb0_valid,
    input  preg_t     wb0_preg,
    input  word_t     wb0_data,
    input  logic      wb1_valid,
    input  preg_t     wb1_preg,
    input  word_t     wb1_data,
    input  logic      done,
    output preg_vec_t pending,
    output preg_vec_t poisoned,
    output preg_vec_t readers,
    output int        pending_count,
    output int        mismatch_errors,
    output int        other_errors
);

    // register image in program order
    word_t      image    [PREG_COUNT];
    int         disp_cyc [PREG_COUNT];
    preg_t      src_l_of [PREG_COUNT];
    preg_t      src_r_of [PREG_COUNT];
    int         cyc;
    logic       prev_flush;
    logic       seen_dual;
    logic       saw_blocked;
    logic       recovered;
    logic       final_done;
    logic [8:0] op_seen;

    function automatic word_t model_alu(alu_op_e op, word_t a, word_t b, imm_t imm);
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLL:  return a << b[4:0];
            ALU_SRL:  return a >> b[4:0];
            ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_ADDI: return a + {{16{imm[15]}}, imm};
            default:  return '0;
        endcase
    endfunction

    always_comb begin
        readers = '0;
        for (int d = 0; d < PREG_COUNT; d++) begin
            if (pending[d]) begin
                readers[src_l_of[d]] = 1'b1;
                readers[src_r_of[d]] = 1'b1;
            end
        end
    end

    task automatic check_wb(input logic valid, input preg_t p, input word_t data,
                            input string name);
        if (valid) begin
            if (!pending[p]) begin
                $display("%0t: writeback to register %0d with no pending uop", $time, p);
                other_errors++;
            end else begin
                if (data !== image[p]) begin
                    $display("Mismatch at %0t: %s = %h, expected %h", $time, name, data,
                             image[p]);
                    mismatch_errors++;
                end
                if (cyc - disp_cyc[p] < 4) begin
                    $display("%0t: register %0d written back only %0d cycles after dispatch",
                             $time, p, cyc - disp_cyc[p]);
                    other_errors++;
                end
                pending[p] = 1'b0;
                pending_count--;
            end
        end
    endtask

    task automatic record_dispatch();
        image[disp_dst]    = model_alu(disp_op, image[disp_src_l], image[disp_src_r], disp_imm);
        pending[disp_dst]  = 1'b1;
        poisoned[disp_dst] = 1'b0;
        disp_cyc[disp_dst] = cyc;
        src_l_of[disp_dst] = disp_src_l;
        src_r_of[disp_dst] = disp_src_r;
        op_seen[disp_op]   = 1'b1;
        pending_count++;
    endtask

    task automatic check_age();
        for (int p = 0; p < PREG_COUNT; p++) begin
            if (pending[p] && cyc - disp_cyc[p] > 300) begin
                $display("%0t: register %0d got no writeback within 300 cycles", $time, p);
                other_errors++;
                pending[p] = 1'b0;
                pending_count--;
            end
        end
    endtask

    task automatic final_report();
        final_done = 1'b1;
        if (op_seen != '1) begin
            $display("not every ALU operation was dispatched");
            other_errors++;
        end
        if (!seen_dual) begin
            $display("never saw both lanes write back in the same cycle");
            other_errors++;
        end
        if (!recovered) begin
            $display("disp_ready never went low and came back under a dependent chain");
            other_errors++;
        end
        if (pending_count != 0) begin
            $display("%0d uops never wrote back", pending_count);
            other_errors++;
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            for (int p = 0; p < PREG_COUNT; p++) begin
                image[p]    = '0;
                src_l_of[p] = '0;
                src_r_of[p] = '0;
            end
            pending         = '0;
            poisoned        = '0;
            pending_count   = 0;
            mismatch_errors = 0;
            other_errors    = 0;
            cyc             = 0;
            prev_flush      = 1'b0;
            seen_dual       = 1'b0;
            saw_blocked     = 1'b0;
            recovered       = 1'b0;
            final_done      = 1'b0;
            op_seen         = '0;
        end else begin
            cyc++;
            // a writeback in the flush cycle still completes
            check_wb(wb0_valid, wb0_preg, wb0_data, "wb0_data");
            check_wb(wb1_valid, wb1_preg, wb1_data, "wb1_data");
            if (wb0_valid && wb1_valid && wb0_preg != wb1_preg)
                seen_dual = 1'b1;
            if (prev_flush && !disp_ready) begin
                $display("%0t: disp_ready low in the cycle after flush", $time);
                other_errors++;
            end
            if (!flush && !disp_ready) begin
                saw_blocked = 1'b1;
                if (pending_count < IQ_DEPTH) begin
                    $display("%0t: disp_ready low with only %0d uops pending", $time,
                             pending_count);
                    other_errors++;
                end
            end
            if (saw_blocked && disp_ready)
                recovered = 1'b1;
            if (flush) begin
                poisoned      = poisoned | pending;
                pending       = '0;
                pending_count = 0;
            end
            if (disp_valid && disp_ready && !flush)
                record_dispatch();
            check_age();
            prev_flush = flush;
            if (done && !final_done)
                final_report();
        end
    end

endmodule
